/* compile.f */
+incdir+include
rtl/rx_symbol_pkg.sv
rtl/rx_event_pkg.sv
rtl/symbol_capture.sv
rtl/sequence_decode.sv
rtl/byte_assemble.sv
rtl/iso14443a_rx.sv
verif/rx_asserts.sv
verif/rx_event_checker.sv
verif/tb_iso14443a_rx.sv

/* include/rx_config.svh */
// ==============================
// shared sizes for the 14443-A receive path
// byte width, bit counter width and the
// testbench wait limit
// ==============================

`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// data bits in one byte before its odd parity bit
`define RX_BYTE_BITS 8

// the bit counter must reach RX_BYTE_BITS so it needs one extra bit
`define RX_CNT_W 4

// no testbench wait loop may spin for longer than this many cycles
`define RX_WAIT_LIMIT 200

`endif

/* rtl/byte_assemble.sv */
// ==============================
// byte assembly and odd parity check
// builds one frame event per cycle
// from the decoded bit stream
// ==============================

`timescale 1ns/1ns
`include "rx_config.svh"

module byte_assemble
    import rx_event_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  rx_bit_t      dbit,
    output frame_event_t event_out
);

    // count value at which the next bit is the parity bit
    localparam logic [`RX_CNT_W-1:0] FULL_CNT = `RX_CNT_W'(`RX_BYTE_BITS);

    logic [`RX_BYTE_BITS-1:0] shift_q;
    logic [`RX_CNT_W-1:0]     cnt_q;
    // xor of every bit of the current byte including the parity bit
    logic                     par_q;

    // data arrives LSB first so each bit enters at the top and moves down
    always_ff @(posedge clk) begin
        if (dbit.bit_valid && (cnt_q != FULL_CNT)) begin
            shift_q <= {dbit.value, shift_q[`RX_BYTE_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q     <= '0;
            par_q     <= 1'b0;
            event_out <= '0;
        end else begin
            event_out <= '0;
            if (dbit.soc) begin
                event_out.soc <= 1'b1;
                cnt_q         <= '0;
                par_q         <= 1'b0;
            end else if (dbit.seq_err) begin
                // whatever was collected of this byte is thrown away
                event_out.sequence_error <= 1'b1;
                cnt_q                    <= '0;
                par_q                    <= 1'b0;
            end else if (dbit.eoc) begin
                event_out.eoc <= 1'b1;
                if (cnt_q == FULL_CNT) begin
                    // eight data bits but the parity bit never came
                    event_out.parity_error <= 1'b1;
                end else if (cnt_q != '0) begin
                    // short last byte, right aligned so the low bits hold the data
                    event_out.data_valid <= 1'b1;
                    event_out.data_bits  <= cnt_q[2:0];
                    event_out.data       <= shift_q >> (FULL_CNT - cnt_q);
                end
                cnt_q <= '0;
                par_q <= 1'b0;
            end else if (dbit.bit_valid) begin
                if (cnt_q == FULL_CNT) begin
                    // this is the parity bit, the total must have an odd count of ones
                    if (par_q ^ dbit.value) begin
                        event_out.data_valid <= 1'b1;
                        event_out.data       <= shift_q;
                    end else begin
                        event_out.parity_error <= 1'b1;
                    end
                    cnt_q <= '0;
                    par_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                    par_q <= par_q ^ dbit.value;
                end
            end
        end
    end

endmodule

/* rtl/iso14443a_rx.sv */
// ==============================
// ISO 14443-A receive frame decoder
// capture, Miller decode and byte stages
// ==============================

`timescale 1ns/1ns

module iso14443a_rx
    import rx_symbol_pkg::*;
    import rx_event_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  rx_symbol_t   sym,
    output logic         ack,
    output frame_event_t event_out
);

    // one symbol per strobe from the handshake stage
    logic       sym_strobe;
    rx_symbol_t sym_q;

    // decoded bit or frame marker, one cycle after the strobe
    rx_bit_t    dbit;

    symbol_capture u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .sym        (sym),
        .ack        (ack),
        .sym_strobe (sym_strobe),
        .sym_q      (sym_q)
    );

    sequence_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .sym_strobe (sym_strobe),
        .sym_q      (sym_q),
        .dbit       (dbit)
    );

    byte_assemble u_assemble (
        .clk       (clk),
        .rst_n     (rst_n),
        .dbit      (dbit),
        .event_out (event_out)
    );

endmodule

/* rtl/rx_event_pkg.sv */
// ==============================
// decoder side types
// decoded bit slot, frame event and the
// Miller decoder state
// ==============================

`include "rx_config.svh"

package rx_event_pkg;

    // output of the sequence stage for one symbol
    // at most one of soc, eoc, seq_err and bit_valid is set in a cycle
    typedef struct packed {
        logic soc;
        logic eoc;
        logic seq_err;
        logic bit_valid;
        logic value;
    } rx_bit_t;

    // frame decoder output contract
    // data_bits is only nonzero for a short final byte flagged with eoc
    typedef struct packed {
        logic                     soc;
        logic                     eoc;
        logic                     sequence_error;
        logic                     parity_error;
        logic                     data_valid;
        logic [2:0]               data_bits;
        logic [`RX_BYTE_BITS-1:0] data;
    } frame_event_t;

    // the decoder remembers whether the last symbol stood for a zero or a one
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_AFTER_ZERO = 2'd1,
        ST_AFTER_ONE  = 2'd2
    } seq_state_e;

endpackage

/* rtl/rx_symbol_pkg.sv */
// ==============================
// line side types
// modified Miller sequence codes and the
// symbol payload that travels with req
// ==============================

package rx_symbol_pkg;

    // sequences as reported by the pause detector
    // SEQ_ERR covers any pause pattern that is not X, Y or Z
    typedef enum logic [1:0] {
        SEQ_X   = 2'd0,
        SEQ_Y   = 2'd1,
        SEQ_Z   = 2'd2,
        SEQ_ERR = 2'd3
    } miller_seq_e;

    // one symbol as offered over the four phase handshake
    typedef struct packed {
        miller_seq_e seq;
    } rx_symbol_t;

endpackage

/* rtl/sequence_decode.sv */
// ==============================
// modified Miller sequence decoder
// soc, eoc and sequence error detection
// data bits delayed by one symbol
// ==============================

`timescale 1ns/1ns

module sequence_decode
    import rx_symbol_pkg::*;
    import rx_event_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sym_strobe,
    input  rx_symbol_t sym_q,
    output rx_bit_t    dbit
);

    seq_state_e state_q;

    // the most recent bit is held back until the next bit shows up
    // so that the logic 0 in front of the end sequence never leaves this stage
    logic pend_valid_q;
    logic pend_value_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            pend_valid_q <= 1'b0;
            dbit         <= '0;
        end else begin
            // every flag in dbit is a single cycle pulse
            dbit <= '0;
            if (sym_strobe) begin
                if (state_q == ST_IDLE) begin
                    // only a Z starts a frame, anything else is line noise
                    if (sym_q.seq == SEQ_Z) begin
                        dbit.soc     <= 1'b1;
                        state_q      <= ST_AFTER_ZERO;
                        pend_valid_q <= 1'b0;
                    end
                end else begin
                    case (sym_q.seq)
                        SEQ_X: begin
                            // logic 1 is always an X
                            dbit.bit_valid <= pend_valid_q;
                            dbit.value     <= pend_value_q & pend_valid_q;
                            pend_valid_q   <= 1'b1;
                            pend_value_q   <= 1'b1;
                            state_q        <= ST_AFTER_ONE;
                        end
                        SEQ_Y: begin
                            if (state_q == ST_AFTER_ONE) begin
                                // logic 0 following a 1 is sent as Y
                                dbit.bit_valid <= pend_valid_q;
                                dbit.value     <= pend_value_q & pend_valid_q;
                                pend_valid_q   <= 1'b1;
                                pend_value_q   <= 1'b0;
                                state_q        <= ST_AFTER_ZERO;
                            end else begin
                                // Y after a 0 closes the frame
                                // and the pending 0 was the end of frame bit
                                dbit.eoc     <= 1'b1;
                                pend_valid_q <= 1'b0;
                                state_q      <= ST_IDLE;
                            end
                        end
                        SEQ_Z: begin
                            if (state_q == ST_AFTER_ZERO) begin
                                // logic 0 following a 0 is sent as Z
                                dbit.bit_valid <= pend_valid_q;
                                dbit.value     <= pend_value_q & pend_valid_q;
                                pend_valid_q   <= 1'b1;
                                pend_value_q   <= 1'b0;
                            end else begin
                                // Z may never follow an X
                                dbit.seq_err <= 1'b1;
                                pend_valid_q <= 1'b0;
                                state_q      <= ST_IDLE;
                            end
                        end
                        default: begin
                            // an invalid symbol inside a frame aborts it without eoc
                            dbit.seq_err <= 1'b1;
                            pend_valid_q <= 1'b0;
                            state_q      <= ST_IDLE;
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* rtl/symbol_capture.sv */
// ==============================
// four phase req/ack receiver
// one sym_strobe and one registered
// symbol per completed handshake
// ==============================

`timescale 1ns/1ns

module symbol_capture
    import rx_symbol_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req,
    input  rx_symbol_t sym,
    output logic       ack,
    output logic       sym_strobe,
    output rx_symbol_t sym_q
);

    // waiting for req, or holding ack until the source lets go of req
    typedef enum logic {
        CAP_WAIT = 1'b0,
        CAP_ACK  = 1'b1
    } cap_state_e;

    cap_state_e state_q;

    // ack is simply the registered state so it never glitches
    assign ack = (state_q == CAP_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= CAP_WAIT;
            sym_strobe <= 1'b0;
        end else begin
            sym_strobe <= 1'b0;
            case (state_q)
                CAP_WAIT: begin
                    // a new request, so take it exactly once
                    if (req) begin
                        state_q    <= CAP_ACK;
                        sym_strobe <= 1'b1;
                    end
                end
                default: begin
                    // stay here however long the source keeps req high
                    if (!req) begin
                        state_q <= CAP_WAIT;
                    end
                end
            endcase
        end
    end

    // the symbol is sampled on the same edge that raises ack and sym_strobe
    always_ff @(posedge clk) begin
        if ((state_q == CAP_WAIT) && req) begin
            sym_q <= sym;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_iso14443a_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_iso14443a_rx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
exit 1

/* verif/rx_asserts.sv */
// ==============================
// bound assertions for the receive path
// handshake order, single cycle event
// flags, reset state and legal flag sets
// ==============================

`timescale 1ns/1ns

module rx_asserts
    import rx_event_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         req,
    input logic         ack,
    input frame_event_t event_out
);

    // soc, eoc, sequence_error, parity_error, data_valid
    logic [4:0] flags;

    assign flags = {event_out.soc, event_out.eoc, event_out.sequence_error,
                    event_out.parity_error, event_out.data_valid};

    // only these flag sets can come out of the byte stage
    // data_bits is nonzero only for a short final byte
    function automatic logic legal_combo(input logic [4:0] f, input logic [2:0] nbits);
        case (f)
            5'b00000: legal_combo = (nbits == 3'd0);
            5'b10000: legal_combo = (nbits == 3'd0);
            5'b00100: legal_combo = (nbits == 3'd0);
            5'b01000: legal_combo = (nbits == 3'd0);
            5'b01010: legal_combo = (nbits == 3'd0);
            5'b00010: legal_combo = (nbits == 3'd0);
            5'b00001: legal_combo = (nbits == 3'd0);
            5'b01001: legal_combo = (nbits != 3'd0);
            default:  legal_combo = 1'b0;
        endcase
    endfunction

    // ack follows a request that was seen on the edge before
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // no flag may stay high for two cycles in a row
    flags_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (flags & $past(flags)) == 5'b0)
        else $error("event flag held for more than one cycle");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> (flags == 5'b0) && !ack)
        else $error("ack or event flag high during reset");

    legal_flags: assert property (@(posedge clk) disable iff (!rst_n)
        legal_combo(flags, event_out.data_bits))
        else $error("illegal combination of event flags");

endmodule

/* verif/rx_event_checker.sv */
// ==============================
// frame event checker
// expected event queue, compare of each
// DUT event, event and error counts
// ==============================

`timescale 1ns/1ns

module rx_event_checker
    import rx_event_pkg::*;
(
    input  logic         clk,
    input  frame_event_t event_out,
    input  logic         exp_push,
    input  frame_event_t exp_evt,
    output int           pending,
    output int           checks,
    output int           errors
);

    frame_event_t exp_q [$];
    frame_event_t want;
    frame_event_t mask;

    int pending_n = 0;
    int checks_n  = 0;
    int errors_n  = 0;

    assign pending = pending_n;
    assign checks  = checks_n;
    assign errors  = errors_n;

    function automatic logic has_event(input frame_event_t e);
        has_event = e.soc | e.eoc | e.sequence_error | e.parity_error | e.data_valid;
    endfunction

    always @(posedge clk) begin
        // event_out is read before this edge updates it, so it is the settled value
        if (has_event(event_out)) begin
            if (exp_q.size() == 0) begin
                $display("unexpected event on event_out while nothing was expected: 0x%04h",
                         event_out);
                errors_n++;
            end else begin
                want = exp_q.pop_front();
                mask = '1;
                // data only means something when a byte is delivered
                if (!want.data_valid) begin
                    mask.data = '0;
                end
                checks_n++;
                if ((event_out & mask) !== (want & mask)) begin
                    $display("Mismatch event_out: got 0x%04h expected 0x%04h",
                             event_out & mask, want & mask);
                    errors_n++;
                end
            end
        end
        if (exp_push) begin
            exp_q.push_back(exp_evt);
        end
        pending_n = exp_q.size();
    end

endmodule

/* verif/tb_iso14443a_rx.sv */
// ==============================
// testbench for the 14443-A receive path
// clock, reset, LFSR data, frame table,
// Miller encoder and four phase driver
// ==============================

`timescale 1ns/1ns
`include "rx_config.svh"

module tb_iso14443a_rx
    import rx_symbol_pkg::*;
    import rx_event_pkg::*;
();

    localparam int NUM_ROWS = 8;

    typedef enum int {
        ERR_NONE,
        ERR_PARITY,
        ERR_Z_AFTER_X,
        ERR_SEQ
    } err_kind_e;

    // one frame to send, with the error to inject and where
    typedef struct {
        string     name;
        int        full_bytes;
        int        part_bits;
        err_kind_e err;
        int        err_pos;
        bit        noise;
    } frame_row_t;

    logic         clk;
    logic         rst_n;
    logic         req;
    logic         ack;
    rx_symbol_t   sym;
    frame_event_t event_out;
    logic         exp_push;
    frame_event_t exp_evt;
    int           pending;
    int           checks;
    int           chk_errors;

    int           tb_errors = 0;
    logic [31:0]  lfsr_q = 32'h3899583d;
    frame_row_t   rows [NUM_ROWS];
    miller_seq_e  sym_list [$];
    frame_event_t exp_list [$];
    logic         bit_list [$];

    iso14443a_rx dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .sym       (sym),
        .ack       (ack),
        .event_out (event_out)
    );

    rx_event_checker chk0 (
        .clk       (clk),
        .event_out (event_out),
        .exp_push  (exp_push),
        .exp_evt   (exp_evt),
        .pending   (pending),
        .checks    (checks),
        .errors    (chk_errors)
    );

    bind iso14443a_rx rx_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .event_out (event_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================
    // data source and table
    // ============================

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
    endtask

    task automatic add_row(input int idx, input string name, input int nb, input int np,
                           input err_kind_e ek, input int pos, input bit noise);
        rows[idx].name       = name;
        rows[idx].full_bytes = nb;
        rows[idx].part_bits  = np;
        rows[idx].err        = ek;
        rows[idx].err_pos    = pos;
        rows[idx].noise      = noise;
    endtask

    task automatic load_table();
        add_row(0, "four bytes after noise", 4, 0, ERR_NONE, 0, 1'b1);
        add_row(1, "short frame of 7 bits", 0, 7, ERR_NONE, 0, 1'b0);
        add_row(2, "two bytes and 3 bits", 2, 3, ERR_NONE, 0, 1'b0);
        add_row(3, "flipped parity", 3, 0, ERR_PARITY, 1, 1'b0);
        add_row(4, "z after x", 3, 0, ERR_Z_AFTER_X, 2, 1'b0);
        add_row(5, "frame after z abort", 2, 0, ERR_NONE, 0, 1'b0);
        add_row(6, "seq_err symbol", 2, 0, ERR_SEQ, 1, 1'b0);
        add_row(7, "frame after seq_err", 1, 4, ERR_NONE, 0, 1'b1);
    endtask

    // fills bit_list with the frame bits and exp_list with the events they must give
    task automatic build_frame(input frame_row_t r);
        logic [`RX_BYTE_BITS-1:0] data;
        logic                     b;
        logic                     par;
        int                       stop_byte;
        int                       i;
        int                       k;
        frame_event_t             e;
        bit_list.delete();
        exp_list.delete();
        e = '0;
        e.soc = 1'b1;
        exp_list.push_back(e);
        // an aborted frame stops at the byte where the bad symbol goes
        stop_byte = (r.err == ERR_Z_AFTER_X || r.err == ERR_SEQ) ? r.err_pos : r.full_bytes;
        for (i = 0; i < stop_byte; i++) begin
            data = '0;
            for (k = 0; k < `RX_BYTE_BITS; k++) begin
                take_bit(b);
                data[k] = b;
                bit_list.push_back(b);
            end
            // odd parity makes the total count of ones odd
            par = ~^data;
            e = '0;
            if (r.err == ERR_PARITY && i == r.err_pos) begin
                par = ~par;
                e.parity_error = 1'b1;
            end else begin
                e.data_valid = 1'b1;
                e.data = data;
            end
            bit_list.push_back(par);
            exp_list.push_back(e);
        end
        e = '0;
        if (r.err == ERR_Z_AFTER_X || r.err == ERR_SEQ) begin
            e.sequence_error = 1'b1;
        end else begin
            data = '0;
            for (k = 0; k < r.part_bits; k++) begin
                take_bit(b);
                data[k] = b;
                bit_list.push_back(b);
            end
            e.eoc = 1'b1;
            if (r.part_bits > 0) begin
                e.data_valid = 1'b1;
                e.data_bits  = r.part_bits[2:0];
                e.data       = data;
            end
        end
        exp_list.push_back(e);
    endtask

    // ============================
    // Miller encoder and driver
    // ============================

    task automatic encode_frame(input frame_row_t r);
        logic prev_one;
        logic aborted;
        sym_list.delete();
        aborted = (r.err == ERR_Z_AFTER_X || r.err == ERR_SEQ);
        if (r.noise) begin
            sym_list.push_back(SEQ_X);
            sym_list.push_back(SEQ_Y);
            sym_list.push_back(SEQ_ERR);
        end
        // start of communication counts as a logic 0 for the next bit
        sym_list.push_back(SEQ_Z);
        prev_one = 1'b0;
        if (!aborted) begin
            bit_list.push_back(1'b0);
        end
        foreach (bit_list[j]) begin
            if (bit_list[j]) begin
                sym_list.push_back(SEQ_X);
            end else begin
                sym_list.push_back(prev_one ? SEQ_Y : SEQ_Z);
            end
            prev_one = bit_list[j];
        end
        if (aborted) begin
            // the X releases the last parity bit, then the bad symbol ends the frame
            sym_list.push_back(SEQ_X);
            sym_list.push_back(r.err == ERR_SEQ ? SEQ_ERR : SEQ_Z);
        end else begin
            sym_list.push_back(SEQ_Y);
        end
    endtask

    // called on a falling edge, returns on the falling edge where req and ack are both low
    task automatic send_symbol(input miller_seq_e s);
        int cnt;
        sym.seq = s;
        req = 1'b1;
        cnt = 0;
        while (ack !== 1'b1 && cnt < `RX_WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== 1'b1) begin
            $display("timeout: ack never rose for symbol %s", s.name());
            tb_errors++;
        end
        req = 1'b0;
        cnt = 0;
        while (ack !== 1'b0 && cnt < `RX_WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== 1'b0) begin
            $display("timeout: ack never fell after req dropped");
            tb_errors++;
        end
    endtask

    task automatic push_expected();
        foreach (exp_list[j]) begin
            exp_evt = exp_list[j];
            exp_push = 1'b1;
            @(negedge clk);
        end
        exp_push = 1'b0;
    endtask

    task automatic check_quiet();
        if (ack !== 1'b0) begin
            $display("Mismatch ack: got 0x%0h expected 0x0", ack);
            tb_errors++;
        end
        if ({event_out.soc, event_out.eoc, event_out.sequence_error,
             event_out.parity_error, event_out.data_valid} !== 5'b0) begin
            $display("Mismatch event_out: got 0x%04h expected 0x0000", event_out);
            tb_errors++;
        end
    endtask

    // ============================
    // main sequence
    // ============================

    initial begin
        int base;
        int cnt;
        int t;
        rst_n    = 1'b0;
        req      = 1'b0;
        sym      = '0;
        exp_push = 1'b0;
        exp_evt  = '0;
        load_table();
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet();
        for (t = 0; t < NUM_ROWS; t++) begin
            base = tb_errors + chk_errors;
            build_frame(rows[t]);
            encode_frame(rows[t]);
            push_expected();
            foreach (sym_list[j]) begin
                send_symbol(sym_list[j]);
            end
            cnt = 0;
            while (pending != 0 && cnt < `RX_WAIT_LIMIT) begin
                @(negedge clk);
                cnt++;
            end
            if (pending != 0) begin
                $display("timeout: %0d expected events never came in test %s",
                         pending, rows[t].name);
                tb_errors++;
            end
            // an extra event would show up within two cycles of the last handshake
            repeat (2) @(negedge clk);
            if (tb_errors + chk_errors == base) begin
                $display("test %-24s ok", rows[t].name);
            end else begin
                $display("test %-24s fail, %0d errors", rows[t].name,
                         tb_errors + chk_errors - base);
            end
        end
        $display("tests %0d, events checked %0d, errors %0d",
                 NUM_ROWS, checks, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
